// ==== src/cpu_pkg.sv ====
/* shared widths, opcodes, control encodings and stage types of the rv32i
   subset core; every rtl module imports this package */
package cpu_pkg;

    localparam int xlen   = 32;
    localparam int addr_w = 16;

    typedef logic [xlen-1:0]   word_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [4:0]        reg_idx_t;

    // base opcodes, bits [6:0]
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // -------------------------------------------------------------------
    // instruction formats, msb first
    // -------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, read through whichever format applies
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // -------------------------------------------------------------------
    // control encodings
    // -------------------------------------------------------------------
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
        alu_sltu, alu_sll, alu_srl, alu_sra, alu_pass_b
    } alu_op_e;

    // operand pair: a from rs1, pc or zero; b from rs2 or imm
    typedef enum logic [1:0] {
        src_reg, src_imm, src_pc_imm, src_zero_imm
    } alu_src_e;

    // five kinds, so three bits
    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_jal, br_jalr
    } branch_e;

    typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_op_e;

    typedef enum logic [1:0] {wb_none, wb_alu, wb_mem, wb_pc4} wb_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        alu_src_e alu_src;
        branch_e  branch;
        mem_op_e  mem_op;
        wb_sel_e  wb_sel;
    } ctrl_t;

    // no-op control, also what an unknown opcode decodes to
    localparam ctrl_t ctrl_nop = '{
        alu_op:  alu_add,
        alu_src: src_reg,
        branch:  br_none,
        mem_op:  mem_none,
        wb_sel:  wb_none
    };

    typedef enum logic [4:0] {
        st_if  = 5'b00001,
        st_id  = 5'b00010,
        st_ex  = 5'b00100,
        st_mem = 5'b01000,
        st_wb  = 5'b10000
    } stage_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  rd;
        logic  wr;
    } data_req_t;

endpackage

// ==== src/decoder.sv ====
/* combinational instruction decoder; maps one fetched word to the control
   struct and its sign-extended immediate */
`timescale 1ns/1ns

module decoder (
    input  cpu_pkg::instr_u instr,
    output cpu_pkg::ctrl_t  ctrl,
    output cpu_pkg::word_t  imm
);
    import cpu_pkg::*;

    // funct3 plus the alternate bit (instr[30]) to an alu operation
    function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    // -------------------------------------------------------------------
    // control fields
    // -------------------------------------------------------------------
    always_comb begin
        ctrl = ctrl_nop;
        case (instr.r.opcode)
            op_reg: begin
                ctrl.alu_op = arith_op(instr.r.funct3, instr.r.funct7[5]);
                ctrl.wb_sel = wb_alu;
            end
            op_imm: begin
                // bit 30 only selects sra over srl, elsewhere it is immediate
                ctrl.alu_op  = arith_op(instr.r.funct3,
                                        instr.r.funct3 == 3'b101 && instr.r.funct7[5]);
                ctrl.alu_src = src_imm;
                ctrl.wb_sel  = wb_alu;
            end
            op_load: begin
                ctrl.alu_src = src_imm;
                ctrl.mem_op  = mem_read;
                ctrl.wb_sel  = wb_mem;
            end
            op_store: begin
                ctrl.alu_src = src_imm;
                ctrl.mem_op  = mem_write;
            end
            op_branch: begin
                ctrl.alu_op = alu_sub;
                case (instr.r.funct3)
                    3'b000:  ctrl.branch = br_eq;
                    3'b001:  ctrl.branch = br_ne;
                    default: ctrl.branch = br_none;
                endcase
            end
            op_lui: begin
                ctrl.alu_op  = alu_pass_b;
                ctrl.alu_src = src_zero_imm;
                ctrl.wb_sel  = wb_alu;
            end
            op_auipc: begin
                ctrl.alu_src = src_pc_imm;
                ctrl.wb_sel  = wb_alu;
            end
            op_jal: begin
                ctrl.alu_src = src_pc_imm;
                ctrl.branch  = br_jal;
                ctrl.wb_sel  = wb_pc4;
            end
            op_jalr: begin
                ctrl.alu_src = src_imm;
                ctrl.branch  = br_jalr;
                ctrl.wb_sel  = wb_pc4;
            end
            default: ctrl = ctrl_nop;
        endcase
    end

    // immediate per format
    always_comb begin
        case (instr.r.opcode)
            op_imm, op_load, op_jalr:
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            op_store:
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            op_branch:
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            op_lui, op_auipc:
                imm = {instr.u.imm, 12'b0};
            op_jal:
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                       instr.j.imm11, instr.j.imm10_1, 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
/* 32 x 32 register file, two asynchronous reads and one synchronous write;
   x0 is not stored and always reads zero */
`timescale 1ns/1ns

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    input  cpu_pkg::reg_idx_t rd,
    input  logic              we,
    input  cpu_pkg::word_t    wdata,
    output cpu_pkg::word_t    rs1_data,
    output cpu_pkg::word_t    rs2_data
);
    import cpu_pkg::*;

    word_t regs [31:1];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/alu.sv ====
/* combinational alu for the execute stage; the equal flag drives the
   beq/bne decision in the memory stage */
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::word_t  a,
    input  cpu_pkg::word_t  b,
    input  cpu_pkg::alu_op_e op,
    output cpu_pkg::word_t  result,
    output logic            equal
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    // only the low five bits count for shifts
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_slt:    result = word_t'($signed(a) < $signed(b));
            alu_sltu:   result = word_t'(a < b);
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = word_t'($signed(a) >>> shamt);
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    assign equal = (a == b);

endmodule

// ==== src/cpu_top.sv ====
/* five-stage sequential rv32i subset core, one instruction in flight at a
   time; both memories answer one cycle after their strobe */
`timescale 1ns/1ns

module cpu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    output logic               inst_fetch,
    output cpu_pkg::addr_t     inst_addr,
    input  cpu_pkg::word_t     instruction,
    output cpu_pkg::data_req_t data_req,
    input  cpu_pkg::word_t     read_data
);
    import cpu_pkg::*;

    stage_t   stage;
    logic     step;
    word_t    pc;

    instr_u   instr_word;
    ctrl_t    dec_ctrl;
    word_t    dec_imm;
    word_t    rs1_data;
    word_t    rs2_data;

    // id/ex
    ctrl_t    id_ex_ctrl;
    word_t    id_ex_rs1;
    word_t    id_ex_rs2;
    word_t    id_ex_imm;
    word_t    id_ex_pc;
    reg_idx_t id_ex_rd;

    // ex/mem
    word_t    ex_mem_result;
    logic     ex_mem_equal;
    word_t    ex_mem_rs2;

    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    logic     alu_equal;
    logic     taken;
    word_t    target;
    logic     wb_we;
    word_t    wb_data;

    // -------------------------------------------------------------------
    // stage sequencer
    // -------------------------------------------------------------------
    // reset and a low rdy both freeze the sequence and mask the strobes
    assign step = rdy && rst;

    // one-hot rotate if -> id -> ex -> mem -> wb -> if
    always_ff @(posedge clk) begin
        if (!rst) begin
            stage <= st_if;
        end else if (step) begin
            stage <= stage_t'({stage[3:0], stage[4]});
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= '0;
        end else if (step && stage == st_mem) begin
            pc <= taken ? target : pc + word_t'(4);
        end
    end

    assign inst_fetch = step && stage == st_if;
    assign inst_addr  = pc[addr_w-1:0];

    // -------------------------------------------------------------------
    // decode is valid during the id cycle
    // -------------------------------------------------------------------
    assign instr_word = instruction;

    decoder u_decoder (
        .instr (instr_word),
        .ctrl  (dec_ctrl),
        .imm   (dec_imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (instr_word.r.rs1),
        .rs2      (instr_word.r.rs2),
        .rd       (id_ex_rd),
        .we       (wb_we),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            id_ex_ctrl <= ctrl_nop;
        end else if (step && stage == st_id) begin
            id_ex_ctrl <= dec_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (step && stage == st_id) begin
            id_ex_rs1 <= rs1_data;
            id_ex_rs2 <= rs2_data;
            id_ex_imm <= dec_imm;
            id_ex_pc  <= pc;
            id_ex_rd  <= instr_word.r.rd;
        end
    end

    // -------------------------------------------------------------------
    // execute
    // -------------------------------------------------------------------
    always_comb begin
        case (id_ex_ctrl.alu_src)
            src_pc_imm:   alu_a = id_ex_pc;
            src_zero_imm: alu_a = '0;
            default:      alu_a = id_ex_rs1;
        endcase
        alu_b = (id_ex_ctrl.alu_src == src_reg) ? id_ex_rs2 : id_ex_imm;
    end

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (id_ex_ctrl.alu_op),
        .result (alu_result),
        .equal  (alu_equal)
    );

    always_ff @(posedge clk) begin
        if (step && stage == st_ex) begin
            ex_mem_result <= alu_result;
            ex_mem_equal  <= alu_equal;
            ex_mem_rs2    <= id_ex_rs2;
        end
    end

    // -------------------------------------------------------------------
    // memory access and next pc
    // -------------------------------------------------------------------
    always_comb begin
        case (id_ex_ctrl.branch)
            br_eq:            taken = ex_mem_equal;
            br_ne:            taken = !ex_mem_equal;
            br_jal, br_jalr:  taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    // jalr target comes from the alu with bit 0 cleared
    assign target = (id_ex_ctrl.branch == br_jalr) ? {ex_mem_result[xlen-1:1], 1'b0}
                                                   : id_ex_pc + id_ex_imm;

    always_comb begin
        data_req.addr  = ex_mem_result[addr_w-1:0];
        data_req.wdata = ex_mem_rs2;
        data_req.rd    = step && stage == st_mem && id_ex_ctrl.mem_op == mem_read;
        data_req.wr    = step && stage == st_mem && id_ex_ctrl.mem_op == mem_write;
    end

    // -------------------------------------------------------------------
    // write back with the read data arriving in this cycle
    // -------------------------------------------------------------------
    always_comb begin
        case (id_ex_ctrl.wb_sel)
            wb_mem:  wb_data = read_data;
            wb_pc4:  wb_data = id_ex_pc + word_t'(4);
            default: wb_data = ex_mem_result;
        endcase
    end

    assign wb_we = step && stage == st_wb && id_ex_ctrl.wb_sel != wb_none;

endmodule

// ==== test/cpu_assert.sv ====
/* bound checks on the memory strobes of cpu_top, attached with bind below */
`timescale 1ns/1ns

module cpu_assert (
    input logic               clk,
    input logic               rst,
    input logic               inst_fetch,
    input cpu_pkg::data_req_t data_req
);
    import cpu_pkg::*;

    // reset keeps the core quiet
    quiet_in_reset: assert property (@(posedge clk)
        !rst |-> !inst_fetch && !data_req.rd && !data_req.wr)
        else $error("strobe high while rst is asserted");

    one_data_op: assert property (@(posedge clk) !(data_req.rd && data_req.wr))
        else $error("data read and write strobes high together");

    // one instruction in flight, so fetches sit at least five cycles apart
    fetch_spacing: assert property (@(posedge clk) disable iff (!rst)
        inst_fetch |-> !$past(inst_fetch, 1) && !$past(inst_fetch, 2)
                       && !$past(inst_fetch, 3) && !$past(inst_fetch, 4))
        else $error("fetch strobe within four cycles of the previous one");

endmodule

bind cpu_top cpu_assert u_cpu_assert (
    .clk        (clk),
    .rst        (rst),
    .inst_fetch (inst_fetch),
    .data_req   (data_req)
);

// ==== test/cpu_tb.sv ====
/* testbench for cpu_top; runs a table-built program twice, the second time
   with random rdy pauses, and checks every store against the expected table */
`timescale 1ns/1ns

module cpu_tb;
    import cpu_pkg::*;

    typedef struct packed {
        addr_t addr;
        word_t data;
    } store_t;

    logic      clk = 1'b0;
    logic      rst = 1'b0;
    logic      rdy = 1'b0;
    logic      inst_fetch;
    addr_t     inst_addr;
    word_t     instruction = '0;
    data_req_t data_req;
    word_t     read_data = '0;

    word_t     imem [128];
    word_t     dmem [64];
    word_t     fill [64];
    bit        skip_mask [128];
    store_t    exp_q [$];
    string     exp_label [$];
    int        rows = 0;

    logic      pauses_on = 1'b0;
    logic [2:0] pause_left = '0;
    word_t     pause_rnd = 32'he0f3;
    int        steps = 0;
    bit        first_fetch = 1'b1;

    int        tests = 0;
    int        fails = 0;
    int        mon_errs = 0;
    bit        timed_out = 1'b0;

    cpu_top DUT (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .inst_fetch  (inst_fetch),
        .inst_addr   (inst_addr),
        .instruction (instruction),
        .data_req    (data_req),
        .read_data   (read_data)
    );

    always #2 clk = ~clk;

    function automatic word_t xorshift(input word_t x);
        word_t v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // -------------------------------------------------------------------
    // instruction encoders
    // -------------------------------------------------------------------
    function automatic word_t r_word(input int f7, input int f3, input int rd,
                                     input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
    endfunction

    function automatic word_t i_word(input logic [6:0] op, input int f3, input int rd,
                                     input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t s_word(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
    endfunction

    function automatic word_t b_word(input int f3, input int rs1, input int rs2,
                                     input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                op_branch};
    endfunction

    function automatic word_t u_word(input logic [6:0] op, input int rd, input int imm);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic word_t j_word(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
    endfunction

    // pc of the next row
    function automatic word_t here();
        return word_t'(8 * rows);
    endfunction

    // one row is the instruction plus a SW of rs to 0x40 + 4*row
    task automatic add_row(input word_t instr, input int rs, input bit stored,
                           input word_t result, input string label);
        addr_t st_addr;
        st_addr = addr_t'('h40 + 4 * rows);
        imem[2 * rows] = instr;
        imem[2 * rows + 1] = s_word(rs, 0, 'h40 + 4 * rows);
        if (stored) begin
            exp_q.push_back('{addr: st_addr, data: result});
            exp_label.push_back(label);
        end else begin
            skip_mask[2 * rows + 1] = 1'b1;
        end
        rows++;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t want,
                              inout int errs);
        if (got !== want) begin
            $display("Fail %s got %h expected %h", name, got, want);
            errs++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t want,
                              inout int errs);
        if (got !== want) begin
            $display("Fail %s got %h expected %h", name, got, want);
            errs++;
        end
    endtask

    task automatic wait_store(output bit seen, output data_req_t req);
        seen = 1'b0;
        req = '0;
        // generous bound, pauses stretch an instruction well past 5 cycles
        for (int n = 0; n < 200 && !seen; n++) begin
            @(posedge clk);
            if (data_req.wr) begin
                seen = 1'b1;
                req = data_req;
            end
        end
    endtask

    // -------------------------------------------------------------------
    // memory models, answer one cycle after the strobe
    // -------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= fill[i];
            end
        end else begin
            if (inst_fetch) begin
                instruction <= imem[inst_addr[8:2]];
            end
            if (data_req.rd) begin
                read_data <= dmem[data_req.addr[7:2]];
            end
            if (data_req.wr) begin
                dmem[data_req.addr[7:2]] <= data_req.wdata;
            end
        end
    end

    // rdy driver, pauses of 3 to 6 cycles when enabled
    always @(posedge clk) begin
        pause_rnd <= xorshift(pause_rnd);
        if (pause_left != 0) begin
            rdy <= 1'b0;
            pause_left <= pause_left - 3'd1;
        end else if (pauses_on && pause_rnd[3:0] == 4'h0) begin
            rdy <= 1'b0;
            pause_left <= 3'd2 + 3'(pause_rnd[5:4]);
        end else begin
            rdy <= 1'b1;
        end
    end

    // strobe monitor; steps counts ready cycles since the last fetch
    always @(posedge clk) begin
        if (!rst) begin
            if (inst_fetch || data_req.rd || data_req.wr) begin
                $display("a strobe was seen while reset was asserted");
                mon_errs++;
            end
            first_fetch <= 1'b1;
            steps <= 0;
        end else begin
            if (!rdy && (inst_fetch || data_req.rd || data_req.wr)) begin
                $display("a strobe was seen while rdy was low");
                mon_errs++;
            end
            if (inst_fetch) begin
                if (first_fetch) begin
                    check_addr("inst_addr", inst_addr, '0, mon_errs);
                end else if (steps != 5) begin
                    $display("a fetch came %0d ready cycles after the previous one", steps);
                    mon_errs++;
                end
                if (skip_mask[inst_addr[8:2]]) begin
                    $display("an instruction that should be skipped was fetched at %h",
                             inst_addr);
                    mon_errs++;
                end
                first_fetch <= 1'b0;
                steps <= 1;
            end else if (rdy) begin
                steps <= steps + 1;
            end
        end
    end

    initial begin
        word_t     state;
        word_t     link;
        data_req_t req;
        bit        seen;
        int        errs;

        state = 32'he0f3;
        for (int i = 0; i < 64; i++) begin
            state = xorshift(state);
            fill[i] = state;
        end
        // unused program space holds a jal x0, 0 self loop
        for (int i = 0; i < 128; i++) begin
            imem[i] = 32'h0000006f;
            skip_mask[i] = 1'b0;
        end

        // ---------------------------------------------------------------
        // program and expected stores
        // ---------------------------------------------------------------
        add_row(i_word(op_imm, 0, 1, 0, 100), 1, 1, 32'h00000064, "addi");
        add_row(i_word(op_imm, 0, 2, 0, -7), 2, 1, 32'hfffffff9, "addi negative");
        add_row(i_word(op_imm, 0, 10, 0, 4), 10, 1, 32'h00000004, "addi shift amount");
        add_row(r_word('h00, 0, 3, 1, 2), 3, 1, 32'h0000005d, "add");
        add_row(r_word('h20, 0, 3, 1, 2), 3, 1, 32'h0000006b, "sub");
        add_row(r_word('h00, 7, 3, 1, 2), 3, 1, 32'h00000060, "and");
        add_row(r_word('h00, 6, 3, 1, 2), 3, 1, 32'hfffffffd, "or");
        add_row(r_word('h00, 4, 3, 1, 2), 3, 1, 32'hffffff9d, "xor");
        add_row(r_word('h00, 2, 3, 2, 1), 3, 1, 32'h00000001, "slt signed");
        add_row(r_word('h00, 3, 3, 2, 1), 3, 1, 32'h00000000, "sltu unsigned");
        add_row(r_word('h00, 1, 3, 2, 10), 3, 1, 32'hffffff90, "sll");
        add_row(r_word('h00, 5, 3, 2, 10), 3, 1, 32'h0fffffff, "srl");
        add_row(r_word('h20, 5, 3, 2, 10), 3, 1, 32'hffffffff, "sra");
        add_row(i_word(op_imm, 7, 3, 2, 'h0f0), 3, 1, 32'h000000f0, "andi");
        add_row(i_word(op_imm, 6, 3, 1, 'h703), 3, 1, 32'h00000767, "ori");
        add_row(i_word(op_imm, 4, 3, 1, -1), 3, 1, 32'hffffff9b, "xori");
        add_row(i_word(op_imm, 2, 3, 2, 5), 3, 1, 32'h00000001, "slti signed");
        add_row(i_word(op_imm, 3, 3, 2, 5), 3, 1, 32'h00000000, "sltiu unsigned");
        add_row(i_word(op_imm, 1, 3, 2, 3), 3, 1, 32'hffffffc8, "slli");
        add_row(i_word(op_imm, 5, 3, 2, 28), 3, 1, 32'h0000000f, "srli");
        add_row(i_word(op_imm, 5, 3, 2, 'h402), 3, 1, 32'hfffffffe, "srai");
        add_row(u_word(op_lui, 3, 'habcde), 3, 1, 32'habcde000, "lui");
        add_row(u_word(op_auipc, 3, 'h12345), 3, 1, 32'h12345000 + here(), "auipc");
        add_row(i_word(op_load, 2, 4, 0, 'h14), 4, 1, fill[5], "lw then sw");
        add_row(i_word(op_imm, 0, 0, 1, 55), 0, 1, 32'h00000000, "write to x0");
        add_row(b_word(0, 1, 1, 8), 3, 0, '0, "beq taken");
        add_row(b_word(0, 1, 2, 8), 1, 1, 32'h00000064, "beq not taken");
        add_row(b_word(1, 1, 2, 8), 3, 0, '0, "bne taken");
        add_row(b_word(1, 1, 1, 8), 1, 1, 32'h00000064, "bne not taken");
        link = here() + 32'd4;
        add_row(j_word(5, 8), 3, 0, '0, "jal");
        add_row(i_word(op_imm, 0, 0, 0, 0), 5, 1, link, "jal link");
        add_row(u_word(op_auipc, 6, 0), 6, 1, here(), "auipc zero");
        // 17 lands two rows on once bit 0 is cleared
        link = here() + 32'd4;
        add_row(i_word(op_jalr, 0, 7, 6, 17), 3, 0, '0, "jalr");
        add_row(i_word(op_imm, 0, 0, 0, 0), 7, 1, link, "jalr link");

        // second pass repeats the program with rdy pauses
        for (int pass = 0; pass < 2 && !timed_out; pass++) begin
            @(posedge clk);
            rst <= 1'b0;
            pauses_on <= 1'b0;
            repeat (4) @(posedge clk);
            rst <= 1'b1;
            pauses_on <= (pass == 1);
            for (int k = 0; k < exp_q.size() && !timed_out; k++) begin
                wait_store(seen, req);
                if (!seen) begin
                    $display("timeout while waiting for the store of test %s", exp_label[k]);
                    timed_out = 1'b1;
                end else begin
                    errs = 0;
                    check_addr("data_req.addr", req.addr, exp_q[k].addr, errs);
                    check_word("data_req.wdata", req.wdata, exp_q[k].data, errs);
                    tests++;
                    if (errs == 0) begin
                        $display("pass %0d test %0d %s: ok", pass, k, exp_label[k]);
                    end else begin
                        $display("pass %0d test %0d %s: mismatch", pass, k, exp_label[k]);
                        fails++;
                    end
                end
            end
        end

        $display("tests %0d, failed %0d, monitor errors %0d, timeouts %0d",
                 tests, fails, mon_errs, timed_out);
        if (fails == 0 && mon_errs == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
src/cpu_pkg.sv
src/decoder.sv
src/reg_file.sv
src/alu.sv
src/cpu_top.sv
test/cpu_assert.sv
test/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the cpu testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f build.f --top-module cpu_tb -Mdir obj_dir
	./obj_dir/Vcpu_tb | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
